//--- cpuId_cfg.svh
`ifndef CPUID_CFG_SVH
`define CPUID_CFG_SVH

// build-time feature enables
`define CPUID_FEAT_WIDE_ISSUE   1'b1
`define CPUID_FEAT_MMU          1'b1
`define CPUID_FEAT_VADDR48      1'b1
`define CPUID_FEAT_FPU          1'b1
`define CPUID_FEAT_FPU_WIDE     1'b0
`define CPUID_FEAT_FMA          1'b1
`define CPUID_FEAT_ALU_WIDE     1'b0

// capability word, bit 0 lands on bit 8 of leaf 1
`define CPUID_CAP_WORD ({12'h000, `CPUID_FEAT_ALU_WIDE, `CPUID_FEAT_FMA, 1'b0, \
	`CPUID_FEAT_FPU_WIDE, `CPUID_FEAT_FPU, 2'b00, `CPUID_FEAT_VADDR48, \
	`CPUID_FEAT_MMU, 2'b00, `CPUID_FEAT_WIDE_ISSUE})

// "QX64C1  ", first character in the low byte
`define CPUID_ARCH_TAG          64'h2020_3143_3436_5851

// generator reset values
`define CPUID_SEED_A            32'h1F2E_3D4C
`define CPUID_SEED_B            32'h5A6B_7C8D

// widths
`define CPUID_TIMER_BITS        12
`define CPUID_LEAF_BITS         5
`define CPUID_MASK_BITS         24
`define CPUID_CORE_BITS         4
`define CPUID_RNG_BITS          32
`define CPUID_WORD_BITS         64

`endif

//--- cpuIdPkg.sv
`include "cpuId_cfg.svh"

package cpuIdPkg;

	// query index, 32 leaves
	typedef logic [`CPUID_LEAF_BITS-1:0] leafIndex;

	// what a given index answers with
	typedef enum logic [2:0] {
		archTag,
		features,
		featMask,
		coreNum,
		reservedTable,
		reservedHigh,
		random
	} leafClass;

	// leaf 1 field layout, low nibble first from the bottom
	typedef struct packed {
		logic [31:0]                  reserved;
		logic [`CPUID_MASK_BITS-1:0]  flags;
		logic [`CPUID_CORE_BITS-1:0]  coreNibble;
		logic [3:0]                   timerNibble;
	} featureFields;

	// leaf 1 as a raw word or as fields
	typedef union packed {
		logic [`CPUID_WORD_BITS-1:0]  raw;
		featureFields                 fields;
	} featureWord;

endpackage

//--- entropyPkg.sv
`include "cpuId_cfg.svh"

package entropyPkg;

	// state of one shift generator
	typedef logic [`CPUID_RNG_BITS-1:0] rngHalf;

	// A high nibble first, B walked from its low end
	function automatic logic [`CPUID_WORD_BITS-1:0] interleave(input rngHalf a, input rngHalf b);
		logic [`CPUID_WORD_BITS-1:0] merged;
		merged = '0;
		for (int i = 0; i < `CPUID_RNG_BITS / 4; i++) begin
			merged[`CPUID_WORD_BITS - 1 - 8 * i -: 4] = a[`CPUID_RNG_BITS - 1 - 4 * i -: 4];
			merged[`CPUID_WORD_BITS - 5 - 8 * i -: 4] = b[4 * i +: 4];
		end
		return merged;
	endfunction

endpackage

//--- timerIf.sv
`include "cpuId_cfg.svh"

interface timerIf;

	logic [`CPUID_TIMER_BITS-1:0] count;
	// top nibble of count
	logic [3:0] timerNibble;
	// count bit 0, feeds the entropy noise chain
	logic noiseBit;
	logic wrap;

	modport source (output count, output timerNibble, output noiseBit, output wrap);

	modport sink (input count, input timerNibble, input noiseBit, input wrap);

endinterface

//--- cycleTimer.sv
`include "cpuId_cfg.svh"

module cycleTimer (
	input logic clock,
	input logic rst,
	timerIf.source timers
);

	logic [`CPUID_TIMER_BITS-1:0] counter;
	logic wrapPulse;

	// free-running, zero while in reset
	always_ff @(posedge clock) begin
		if (rst) begin
			counter <= '0;
			wrapPulse <= 1'b0;
		end else begin
			counter <= counter + 1'b1;
			// high for the one cycle where count is back at zero
			wrapPulse <= &counter;
		end
	end

	assign timers.count = counter;
	assign timers.timerNibble = counter[`CPUID_TIMER_BITS-1 -: 4];
	assign timers.noiseBit = counter[0];
	assign timers.wrap = wrapPulse;

endmodule

//--- featureRegs.sv
`include "cpuId_cfg.svh"

module featureRegs (
	input logic clock,
	input logic rst,
	input logic cfgWrite,
	input logic cfgSel,
	input logic [`CPUID_MASK_BITS-1:0] cfgData,
	output logic [`CPUID_MASK_BITS-1:0] featureMask,
	output logic [`CPUID_CORE_BITS-1:0] coreNum
);

	logic [`CPUID_MASK_BITS-1:0] maskReg;
	logic [`CPUID_CORE_BITS-1:0] coreReg;
	logic maskWrite;
	logic coreWrite;

	// cfgSel 0 is the mask, 1 the core number
	assign maskWrite = cfgWrite && !cfgSel;
	assign coreWrite = cfgWrite && cfgSel;

	// everything advertised until software narrows it
	always_ff @(posedge clock) begin
		if (rst) begin
			maskReg <= '1;
		end else if (maskWrite) begin
			maskReg <= cfgData;
		end
	end

	// only the low bits of the data word are kept
	always_ff @(posedge clock) begin
		if (rst) begin
			coreReg <= '0;
		end else if (coreWrite) begin
			coreReg <= cfgData[`CPUID_CORE_BITS-1:0];
		end
	end

	assign featureMask = maskReg;
	assign coreNum = coreReg;

endmodule

//--- entropySource.sv
`include "cpuId_cfg.svh"

module entropySource (
	input logic clock,
	input logic rst,
	timerIf.sink timers,
	output logic [`CPUID_WORD_BITS-1:0] randWord
);

	import entropyPkg::*;

	rngHalf stateA;
	rngHalf stateB;
	logic feedA;
	logic feedB;
	logic feedALast;
	logic feedBLast;
	logic noiseStage1;
	logic noiseStage2;
	logic noise;

	// each half also takes the partner's previous feedback bit
	always_comb begin
		feedA = ~(stateA[1] ^ stateA[3] ^ stateA[5] ^ stateA[7] ^ noise ^ feedBLast);
		feedB = ~(stateB[1] ^ stateB[3] ^ stateB[5] ^ stateB[7] ^ noise ^ feedALast);
	end

	always_ff @(posedge clock) begin
		if (rst) begin
			stateA <= `CPUID_SEED_A;
			stateB <= `CPUID_SEED_B;
			feedALast <= 1'b0;
			feedBLast <= 1'b0;
		end else begin
			// shift right, new bit enters at the top
			stateA <= {feedA, stateA[`CPUID_RNG_BITS-1:1]};
			stateB <= {feedB, stateB[`CPUID_RNG_BITS-1:1]};
			feedALast <= feedA;
			feedBLast <= feedB;
		end
	end

	// timer bit 0 through two stages, edges show up as noise
	always_ff @(posedge clock) begin
		if (rst) begin
			noiseStage1 <= 1'b0;
			noiseStage2 <= 1'b0;
			noise <= 1'b0;
		end else begin
			noiseStage1 <= timers.noiseBit;
			noiseStage2 <= noiseStage1;
			noise <= noiseStage2 ^ noiseStage1;
		end
	end

	assign randWord = interleave(stateA, stateB);

endmodule

//--- leafTable.sv
`include "cpuId_cfg.svh"

module leafTable (
	input logic clock,
	input logic rst,
	input cpuIdPkg::leafIndex index,
	timerIf.sink timers,
	input logic [`CPUID_MASK_BITS-1:0] featureMask,
	input logic [`CPUID_CORE_BITS-1:0] coreNum,
	input logic [`CPUID_WORD_BITS-1:0] randWord,
	output logic [`CPUID_WORD_BITS-1:0] resLo,
	output logic [`CPUID_WORD_BITS-1:0] resHi
);

	import cpuIdPkg::*;

	leafClass leafKind;
	featureWord featLeaf;
	logic [`CPUID_WORD_BITS-1:0] nextLo;
	logic [`CPUID_WORD_BITS-1:0] nextHi;

	// index to leaf class
	always_comb begin
		case (index) inside
			5'd0: leafKind = archTag;
			5'd1: leafKind = features;
			5'd2: leafKind = featMask;
			5'd3: leafKind = cpuIdPkg::coreNum;
			[5'd4:5'd15]: leafKind = reservedTable;
			5'd31: leafKind = random;
			default: leafKind = reservedHigh;
		endcase
	end

	// leaf 1 built field by field
	always_comb begin
		featLeaf.fields.reserved = '0;
		featLeaf.fields.flags = `CPUID_CAP_WORD & featureMask;
		featLeaf.fields.coreNibble = coreNum;
		featLeaf.fields.timerNibble = timers.timerNibble;
	end

	always_comb begin
		// high word kept for later leaves
		nextHi = '0;
		case (leafKind)
			archTag: nextLo = `CPUID_ARCH_TAG;
			features: nextLo = featLeaf.raw;
			featMask: nextLo = `CPUID_WORD_BITS'(featureMask);
			cpuIdPkg::coreNum: nextLo = `CPUID_WORD_BITS'(coreNum);
			random: nextLo = randWord;
			reservedTable, reservedHigh: nextLo = '0;
			default: nextLo = '0;
		endcase
	end

	// one cycle from index to result
	always_ff @(posedge clock) begin
		if (rst) begin
			resLo <= '0;
			resHi <= '0;
		end else begin
			resLo <= nextLo;
			resHi <= nextHi;
		end
	end

endmodule

//--- cpuIdTop.sv
`include "cpuId_cfg.svh"

module cpuIdTop (
	input logic clock,
	input logic rst,
	input cpuIdPkg::leafIndex index,
	input logic cfgWrite,
	input logic cfgSel,
	input logic [`CPUID_MASK_BITS-1:0] cfgData,
	output logic [`CPUID_WORD_BITS-1:0] resLo,
	output logic [`CPUID_WORD_BITS-1:0] resHi
);

	logic [`CPUID_MASK_BITS-1:0] featureMask;
	logic [`CPUID_CORE_BITS-1:0] coreNum;
	logic [`CPUID_WORD_BITS-1:0] randWord;

	// shared by leafTable and entropySource
	timerIf timers ();

	cycleTimer timerUnit (
		.clock(clock),
		.rst(rst),
		.timers(timers.source)
	);

	featureRegs regUnit (
		.clock(clock),
		.rst(rst),
		.cfgWrite(cfgWrite),
		.cfgSel(cfgSel),
		.cfgData(cfgData),
		.featureMask(featureMask),
		.coreNum(coreNum)
	);

	entropySource rngUnit (
		.clock(clock),
		.rst(rst),
		.timers(timers.sink),
		.randWord(randWord)
	);

	leafTable leafUnit (
		.clock(clock),
		.rst(rst),
		.index(index),
		.timers(timers.sink),
		.featureMask(featureMask),
		.coreNum(coreNum),
		.randWord(randWord),
		.resLo(resLo),
		.resHi(resHi)
	);

endmodule

//--- tb_cpuIdTop.sv
`include "cpuId_cfg.svh"

module tb_cpuIdTop;

	timeunit 1ns;
	timeprecision 1ps;

	import cpuIdPkg::*;
	import entropyPkg::*;

	localparam int MAX_LINES = 64;

	logic clock;
	logic rst;
	leafIndex index;
	logic cfgWrite;
	logic cfgSel;
	logic [`CPUID_MASK_BITS-1:0] cfgData;
	logic [`CPUID_WORD_BITS-1:0] resLo;
	logic [`CPUID_WORD_BITS-1:0] resHi;

	// trace contents
	logic isWrite [MAX_LINES];
	logic selArr [MAX_LINES];
	logic [23:0] dataArr [MAX_LINES];
	int idxArr [MAX_LINES];
	logic useModel [MAX_LINES];
	logic [63:0] expArr [MAX_LINES];
	int lineCount = 0;
	logic traceLoaded = 1'b0;

	// reference model state before the next edge
	logic [`CPUID_TIMER_BITS-1:0] mCount;
	logic [23:0] mMask;
	logic [3:0] mCore;
	rngHalf mA;
	rngHalf mB;
	logic mFaLast;
	logic mFbLast;
	logic mN1;
	logic mN2;
	logic mNoise;

	int errorCount = 0;
	int passCount = 0;
	int failCount = 0;

	cpuIdTop UUT (
		.clock(clock),
		.rst(rst),
		.index(index),
		.cfgWrite(cfgWrite),
		.cfgSel(cfgSel),
		.cfgData(cfgData),
		.resLo(resLo),
		.resHi(resHi)
	);

	always #50 clock = ~clock;

	task automatic compareValue(input string name, input logic [63:0] expected,
			input logic [63:0] actual);
		if (actual !== expected) begin
			$display("FAIL at %0t: %s expected %h, got %h", $time, name, expected, actual);
			errorCount++;
		end
	endtask

	task automatic loadTrace();
		int fd;
		string lineBuf;
		logic [8*8-1:0] opStr;
		logic [8*8-1:0] expStr;
		logic [63:0] expVal;
		int sel;
		logic [23:0] data;
		int idx;
		fd = $fopen("cpuId_trace.txt", "r");
		if (fd == 0) begin
			$display("could not open the trace file cpuId_trace.txt");
		end else begin
			while (!$feof(fd) && lineCount < MAX_LINES) begin
				lineBuf = "";
				void'($fgets(lineBuf, fd));
				if (lineBuf.len() > 1 && lineBuf[0] != "#") begin
					void'($sscanf(lineBuf, "%s %h %h %d %s", opStr, sel, data, idx, expStr));
					isWrite[lineCount] = (opStr == "write");
					selArr[lineCount] = sel[0];
					dataArr[lineCount] = data;
					idxArr[lineCount] = idx;
					useModel[lineCount] = (expStr == "model");
					expVal = '0;
					if (!isWrite[lineCount] && expStr != "model")
						void'($sscanf(lineBuf, "%s %h %h %d %h", opStr, sel, data, idx,
							expVal));
					expArr[lineCount] = expVal;
					lineCount++;
				end
			end
			$fclose(fd);
		end
	endtask

	// answer for leaf idx from the model state before the edge
	function automatic logic [63:0] modelLeaf(input int idx);
		featureWord fw;
		fw.fields.reserved = '0;
		fw.fields.flags = `CPUID_CAP_WORD & mMask;
		fw.fields.coreNibble = mCore;
		fw.fields.timerNibble = mCount[11:8];
		case (idx)
			0: return 64'h2020_3143_3436_5851;
			1: return fw.raw;
			2: return {40'h0, mMask};
			3: return {60'h0, mCore};
			31: return interleave(mA, mB);
			default: return '0;
		endcase
	endfunction

	// one clock edge of the model with line n's write applied
	task automatic stepModel(input int n);
		logic fa;
		logic fb;
		fa = ~(mA[1] ^ mA[3] ^ mA[5] ^ mA[7] ^ mNoise ^ mFbLast);
		fb = ~(mB[1] ^ mB[3] ^ mB[5] ^ mB[7] ^ mNoise ^ mFaLast);
		mA = {fa, mA[31:1]};
		mB = {fb, mB[31:1]};
		mFaLast = fa;
		mFbLast = fb;
		mNoise = mN2 ^ mN1;
		mN2 = mN1;
		mN1 = mCount[0];
		mCount = mCount + 1'b1;
		if (isWrite[n] && !selArr[n])
			mMask = dataArr[n];
		if (isWrite[n] && selArr[n])
			mCore = dataArr[n][3:0];
	endtask

	task automatic driveLine(input int n);
		index <= leafIndex'(idxArr[n]);
		cfgWrite <= isWrite[n];
		cfgSel <= selArr[n];
		cfgData <= dataArr[n];
	endtask

	initial begin
		logic [63:0] expected;
		logic [63:0] lastRand;
		logic haveLastRand;
		int errorsBefore;
		clock = 1'b0;
		rst = 1'b1;
		index = '0;
		cfgWrite = 1'b0;
		cfgSel = 1'b0;
		cfgData = '0;
		haveLastRand = 1'b0;
		lastRand = '0;
		mCount = '0;
		mMask = '1;
		mCore = '0;
		mA = `CPUID_SEED_A;
		mB = `CPUID_SEED_B;
		mFaLast = 1'b0;
		mFbLast = 1'b0;
		mN1 = 1'b0;
		mN2 = 1'b0;
		mNoise = 1'b0;
		loadTrace();
		traceLoaded = 1'b1;

		// results stay zero while reset is held
		for (int c = 0; c < 4; c++) begin
			@(posedge clock);
			if (c == 3) begin
				rst <= 1'b0;
				if (lineCount > 0)
					driveLine(0);
			end
			@(negedge clock);
			compareValue("resLo", '0, resLo);
			compareValue("resHi", '0, resHi);
		end

		for (int n = 0; n < lineCount; n++) begin
			@(posedge clock);
			expected = useModel[n] ? modelLeaf(idxArr[n]) : expArr[n];
			stepModel(n);
			if (n + 1 < lineCount) begin
				driveLine(n + 1);
			end else begin
				index <= '0;
				cfgWrite <= 1'b0;
			end
			@(negedge clock);
			errorsBefore = errorCount;
			compareValue("resHi", '0, resHi);
			if (!isWrite[n])
				compareValue("resLo", expected, resLo);
			if (!isWrite[n] && idxArr[n] == 31) begin
				if (haveLastRand && resLo === lastRand) begin
					$display("leaf 31 gave the same word twice in a row at %0t", $time);
					errorCount++;
				end
				lastRand = resLo;
				haveLastRand = 1'b1;
			end
			if (errorCount == errorsBefore) begin
				passCount++;
				$display("test %0d %s leaf %0d: ok", n, isWrite[n] ? "write" : "read", idxArr[n]);
			end else begin
				failCount++;
				$display("test %0d %s leaf %0d: failed", n, isWrite[n] ? "write" : "read",
					idxArr[n]);
			end
		end

		$display("tests passed %0d, failed %0d, errors %0d", passCount, failCount, errorCount);
		if (errorCount == 0 && lineCount > 0) begin
			$display("Verification passed");
		end else begin
			$display("Verification failed");
		end
		$finish;
	end

	// watchdog
	initial begin
		wait (traceLoaded);
		repeat (200 * lineCount + 20) @(posedge clock);
		$display("timeout, the run did not finish in time");
		$display("Verification failed");
		$finish;
	end

endmodule

//--- cpuId_trace.txt
# op sel data index expected: sel and data are hex, index decimal
# expected is resLo in hex, model means the testbench reference, - for writes
read 0 000000 31 model
read 0 000000 0 2020314334365851
read 0 000000 1 model
read 0 000000 2 0000000000ffffff
read 0 000000 3 0000000000000000
read 0 000000 31 model
read 0 000000 31 model
write 0 00f0f1 0 -
read 0 000000 1 model
read 0 000000 2 000000000000f0f1
write 1 0000a7 0 -
read 0 000000 3 0000000000000007
read 0 000000 1 model
read 0 000000 4 0000000000000000
read 0 000000 17 0000000000000000
read 0 000000 30 0000000000000000
read 0 000000 15 0000000000000000
read 0 000000 16 0000000000000000
read 0 000000 31 model
read 0 000000 0 2020314334365851
read 0 000000 31 model
read 0 000000 2 000000000000f0f1
read 0 000000 3 0000000000000007

//--- build.f
+incdir+.
cpuIdPkg.sv
entropyPkg.sv
timerIf.sv
cycleTimer.sv
featureRegs.sv
entropySource.sv
leafTable.sv
cpuIdTop.sv
tb_cpuIdTop.sv

//--- Makefile
TOP = tb_cpuIdTop

all: run

build:
	verilator --binary --timing -f build.f --top-module $(TOP)

run: build
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Verification passed"

lint:
	verilator --lint-only --timing -f build.f --top-module $(TOP)

clean:
	rm -rf obj_dir

.PHONY: all build run lint clean
